//--- sim/chien_search_tb.sv
// chien search testbench
`timescale 1ns/10ps

module chien_search_tb;
    import chien_pkg::*;

    localparam int CW_LEN     = 544;
    localparam int TIMEOUT    = 5000;
    // x^10 + x^3 + 1
    localparam int FIELD_POLY = 'h409;

    logic       clk_i;
    logic       rst_ni;
    logic       start_req_i;
    logic       root_ack_i;
    gf_elem_t   sigma_i [0:GF_T];
    logic       start_ack_o;
    logic       root_req_o;
    logic       done_o;
    cw_pos_t    root_pos_o;
    root_cnt_t  root_count_o;

    // expected roots of the running case
    logic [CW_LEN-1:0] chosen_vec;
    int                exp_k;
    int                last_pos;
    int                seen_cnt;

    chien_search dut0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_req_i  (start_req_i),
        .root_ack_i   (root_ack_i),
        .sigma_i      (sigma_i),
        .start_ack_o  (start_ack_o),
        .root_req_o   (root_req_o),
        .done_o       (done_o),
        .root_pos_o   (root_pos_o),
        .root_count_o (root_count_o)
    );

    always #4 clk_i = ~clk_i;

    // ====================
    // error reporting
    // ====================

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string sig, input int exp_v, input int act_v);
        $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, sig, exp_v, act_v);
        fail_run();
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s within %0d cycles", $time, what, TIMEOUT);
        fail_run();
    endtask

    // ====================
    // reference field math
    // ====================

    // carry-less product, then fold bits 18..10 back down
    function automatic int gf_mult(input int a, input int b);
        int prod;
        int i;
        prod = 0;
        for (i = 0; i < GF_W; i++) begin
            if ((b >> i) & 1) begin
                prod = prod ^ (a << i);
            end
        end
        for (i = 2 * GF_W - 2; i >= GF_W; i--) begin
            if ((prod >> i) & 1) begin
                prod = prod ^ (FIELD_POLY << (i - GF_W));
            end
        end
        return prod;
    endfunction

    function automatic int gf_pow(input int e);
        int r;
        int i;
        r = 1;
        for (i = 0; i < e % 1023; i++) begin
            r = gf_mult(r, 2);
        end
        return r;
    endfunction

    // ====================
    // checks
    // ====================

    // reset values right after release
    a_rst_ack : assert property (@(posedge clk_i) $rose(rst_ni) |-> !start_ack_o)
        else report_mismatch("start_ack_o", 0, $sampled(start_ack_o));
    a_rst_req : assert property (@(posedge clk_i) $rose(rst_ni) |-> !root_req_o)
        else report_mismatch("root_req_o", 0, $sampled(root_req_o));
    a_rst_done : assert property (@(posedge clk_i) $rose(rst_ni) |-> !done_o)
        else report_mismatch("done_o", 0, $sampled(done_o));
    a_rst_cnt : assert property (@(posedge clk_i)
        $rose(rst_ni) |-> root_count_o == '0)
        else report_mismatch("root_count_o", 0, $sampled(root_count_o));

    // start handshake order
    a_ack_rise : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(start_ack_o) |-> $past(start_req_i))
        else report_mismatch("start_req_i", 1, $past(start_req_i));
    a_ack_fall : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(start_ack_o) |-> !$past(start_req_i))
        else report_mismatch("start_req_i", 0, $past(start_req_i));

    // accepted roots belong to the set and come in descending order
    a_pos_chosen : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (root_req_o && root_ack_i) |-> chosen_vec[root_pos_o])
        else report_mismatch("chosen_vec[root_pos_o]", 1, 0);
    a_pos_desc : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (root_req_o && root_ack_i) |-> int'(root_pos_o) < last_pos)
        else report_mismatch("root_pos_o", last_pos - 1, $sampled(root_pos_o));

    // end of scan
    a_done_cnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_o |-> root_count_o == root_cnt_t'(exp_k))
        else report_mismatch("root_count_o", exp_k, $sampled(root_count_o));
    a_done_seen : assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_o |-> seen_cnt == exp_k)
        else report_mismatch("seen_cnt", exp_k, $sampled(seen_cnt));
    a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_o |=> !done_o)
        else report_mismatch("done_o", 0, $sampled(done_o));

    // root stream four-phase rules
    a_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (root_req_o && !root_ack_i) |=> root_req_o)
        else report_mismatch("root_req_o", 1, $sampled(root_req_o));
    a_pos_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (root_req_o && !root_ack_i) |=> $stable(root_pos_o))
        else report_mismatch("root_pos_o", $past(root_pos_o), $sampled(root_pos_o));
    a_req_drop : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (root_req_o && root_ack_i) |=> !root_req_o)
        else report_mismatch("root_req_o", 0, $sampled(root_req_o));
    a_req_rise : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(root_req_o) |-> !$past(root_ack_i))
        else report_mismatch("root_ack_i", 0, $past(root_ack_i));

    // count accepted roots, remember the last position
    always @(posedge clk_i) begin
        if (root_req_o && root_ack_i) begin
            last_pos <= int'(root_pos_o);
            seen_cnt <= seen_cnt + 1;
        end
    end

    // ====================
    // stimulus
    // ====================

    // k distinct positions, optionally both ends of the codeword
    task automatic pick_positions(input int k, input bit with_ends);
        int cnt;
        int p;
        chosen_vec = '0;
        cnt = 0;
        if (with_ends && k >= 2) begin
            chosen_vec[0]        = 1'b1;
            chosen_vec[CW_LEN-1] = 1'b1;
            cnt = 2;
        end
        while (cnt < k) begin
            p = $urandom_range(CW_LEN - 1, 0);
            if (!chosen_vec[p]) begin
                chosen_vec[p] = 1'b1;
                cnt++;
            end
        end
    endtask

    // product of (1 + alpha^(CW_LEN-1-pos) x)
    task automatic build_sigma();
        int coef [0:GF_T];
        int r;
        int j;
        coef[0] = 1;
        for (j = 1; j <= GF_T; j++) begin
            coef[j] = 0;
        end
        for (int pos = 0; pos < CW_LEN; pos++) begin
            if (chosen_vec[pos]) begin
                r = gf_pow(CW_LEN - 1 - pos);
                for (j = GF_T; j >= 1; j--) begin
                    coef[j] = coef[j] ^ gf_mult(r, coef[j-1]);
                end
            end
        end
        for (j = 0; j <= GF_T; j++) begin
            sigma_i[j] = gf_elem_t'(coef[j]);
        end
    endtask

    task automatic start_scan();
        int n;
        int hold;
        int h;
        start_req_i = 1'b1;
        n = 0;
        while (!start_ack_o) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n > TIMEOUT) begin
                report_timeout("start_ack_o did not rise");
            end
        end
        // keep the request up a little while ack is high
        hold = $urandom_range(5, 0);
        for (h = 0; h < hold; h++) begin
            @(posedge clk_i);
            #1;
        end
        start_req_i = 1'b0;
        n = 0;
        while (start_ack_o) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n > TIMEOUT) begin
                report_timeout("start_ack_o did not fall");
            end
        end
    endtask

    // ack follows root_req_o after 0 to 5 cycles, on raise and on release
    task automatic run_scan();
        int n;
        int ack_wait;
        n = 0;
        ack_wait = -1;
        while (!done_o) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n > TIMEOUT) begin
                report_timeout("done_o did not pulse");
            end
            if (root_ack_i != root_req_o) begin
                if (ack_wait < 0) begin
                    ack_wait = $urandom_range(5, 0);
                end
                if (ack_wait == 0) begin
                    root_ack_i = root_req_o;
                    ack_wait = -1;
                end else begin
                    ack_wait--;
                end
            end
        end
    endtask

    task automatic run_case(input int k, input bit with_ends);
        // let the done checks sample before the case changes
        repeat (2) @(posedge clk_i);
        #1;
        pick_positions(k, with_ends);
        build_sigma();
        exp_k    = k;
        last_pos = CW_LEN;
        seen_cnt = 0;
        start_scan();
        run_scan();
    endtask

    initial begin
        void'($urandom(26413));
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        start_req_i = 1'b0;
        root_ack_i  = 1'b0;
        chosen_vec  = '0;
        exp_k       = 0;
        last_pos    = CW_LEN;
        seen_cnt    = 0;
        for (int j = 0; j <= GF_T; j++) begin
            sigma_i[j] = '0;
        end
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        run_case(0, 1'b0);
        run_case(GF_T, 1'b1);
        run_case(GF_T, 1'b0);
        for (int t = 0; t < 6; t++) begin
            run_case($urandom_range(GF_T, 0), t[0]);
        end

        repeat (2) @(posedge clk_i);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- src.f
src/chien_pkg.sv
src/gf_mul.sv
src/chien_lane.sv
src/batch_counter.sv
src/scan_ctrl.sv
src/root_serializer.sv
src/chien_search.sv
sim/chien_search_tb.sv

//--- src/batch_counter.sv
// batch index counter
`timescale 1ns/10ps

module batch_counter #(
    parameter int LANES  = 4,
    parameter int CW_LEN = 544
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i,
    input  logic               advance_i,
    output chien_pkg::cw_pos_t batch_idx_o,
    output logic               last_batch_o
);
    import chien_pkg::*;

    // ceil(CW_LEN / LANES) batches per scan
    localparam int NUM_BATCH = (CW_LEN + LANES - 1) / LANES;

    cw_pos_t idx_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idx_q <= '0;
        end else if (clear_i) begin
            idx_q <= '0;
        end else if (advance_i && !last_batch_o) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign batch_idx_o  = idx_q;
    assign last_batch_o = (idx_q == cw_pos_t'(NUM_BATCH - 1));

    // once the last batch is stepped, no more steps until a new start
    a_no_step_past_end : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (advance_i && last_batch_o) |=> (!advance_i until clear_i)
    );

endmodule

//--- src/chien_lane.sv
// chien evaluation lane
`timescale 1ns/10ps

module chien_lane #(
    parameter int LANES    = 4,
    parameter int LANE_IDX = 0
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                load_i,
    input  logic                step_i,
    input  chien_pkg::gf_elem_t sigma_i [0:chien_pkg::GF_T],
    output chien_pkg::gf_elem_t sum_o
);
    import chien_pkg::*;

    // term j holds lambda_j * alpha^(-j*idx) for the current index
    gf_elem_t term_q [0:GF_T];

    // one shared multiplier per term j >= 1
    gf_elem_t mul_a [1:GF_T];
    gf_elem_t mul_b [1:GF_T];
    gf_elem_t mul_p [1:GF_T];

    // ====================
    // per-term multipliers
    // ====================

    for (genvar j = 1; j <= GF_T; j++) begin : g_term
        // load weight alpha^(-j*m), step factor alpha^(-j*P)
        localparam gf_elem_t LOAD_W = gf_alpha_pow(-j * LANE_IDX);
        localparam gf_elem_t STEP_W = gf_alpha_pow(-j * LANES);

        // load picks sigma, otherwise recursion on the held term
        assign mul_a[j] = load_i ? sigma_i[j] : term_q[j];
        assign mul_b[j] = load_i ? LOAD_W : STEP_W;

        gf_mul u_mul (
            .a_i (mul_a[j]),
            .b_i (mul_b[j]),
            .p_o (mul_p[j])
        );
    end

    // term 0 weight is always 1, loaded straight and never stepped
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            term_q[0] <= sigma_i[0];
            for (int k = 1; k <= GF_T; k++) begin
                term_q[k] <= mul_p[k];
            end
        end else if (step_i) begin
            for (int k = 1; k <= GF_T; k++) begin
                term_q[k] <= mul_p[k];
            end
        end
    end

    // sigma(alpha^(-idx)) as xor of all terms
    always_comb begin
        sum_o = term_q[0];
        for (int k = 1; k <= GF_T; k++) begin
            sum_o = sum_o ^ term_q[k];
        end
    end

    // controller never overlaps load with a step
    a_load_step_excl : assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(load_i && step_i)
    );

endmodule

//--- src/chien_pkg.sv
// chien search shared definitions

package chien_pkg;

    // ====================
    // field and code constants
    // ====================

    // field width, GF(2^10)
    localparam int GF_W = 10;
    // max correctable roots, sigma has GF_T+1 coefficients
    localparam int GF_T = 11;
    // multiplicative group order
    localparam int GF_ORD = 1023;
    // x^10 + x^3 + 1
    localparam logic [GF_W:0] GF_POLY = 11'h409;

    // ====================
    // types
    // ====================

    typedef logic [GF_W-1:0] gf_elem_t;
    // index or codeword position, 0..1022
    typedef logic [9:0] cw_pos_t;
    // 0..GF_T roots
    typedef logic [3:0] root_cnt_t;

    // scan controller states
    typedef enum logic [2:0] {
        IDLE,
        ACK,
        LOAD,
        SCAN,
        DRAIN,
        DONE
    } scan_state_e;

    // ====================
    // elaboration helpers
    // ====================

    // alpha^e, exponent taken mod 1023 so negative powers work
    function automatic gf_elem_t gf_alpha_pow(input int e);
        int n;
        int k;
        logic [GF_W:0] v;
        n = e % GF_ORD;
        if (n < 0) begin
            n = n + GF_ORD;
        end
        v = 1;
        // repeated multiply by alpha
        for (k = 0; k < n; k++) begin
            v = v << 1;
            if (v[GF_W]) begin
                v = v ^ GF_POLY;
            end
        end
        return v[GF_W-1:0];
    endfunction

endpackage

//--- src/chien_search.sv
// parallel chien search top
`timescale 1ns/10ps

module chien_search #(
    parameter int LANES  = 4,
    parameter int CW_LEN = 544
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 start_req_i,
    input  logic                 root_ack_i,
    input  chien_pkg::gf_elem_t  sigma_i [0:chien_pkg::GF_T],
    output logic                 start_ack_o,
    output logic                 root_req_o,
    output logic                 done_o,
    output chien_pkg::cw_pos_t   root_pos_o,
    output chien_pkg::root_cnt_t root_count_o
);
    import chien_pkg::*;

    // controller strobes
    logic       sigma_capture;
    logic       load;
    logic       step;
    logic       clear;
    logic       busy;
    logic       last_batch;
    cw_pos_t    batch_idx;

    // captured locator, lowest order first
    gf_elem_t   sigma_q  [0:GF_T];
    gf_elem_t   lane_sum [0:LANES-1];
    logic [LANES-1:0] zero_vec;

    always_ff @(posedge clk_i) begin
        if (sigma_capture) begin
            sigma_q <= sigma_i;
        end
    end

    // ====================
    // control
    // ====================

    scan_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .start_req_i     (start_req_i),
        .busy_i          (busy),
        .last_batch_i    (last_batch),
        .start_ack_o     (start_ack_o),
        .sigma_capture_o (sigma_capture),
        .load_o          (load),
        .step_o          (step),
        .clear_o         (clear),
        .done_o          (done_o)
    );

    batch_counter #(.LANES(LANES), .CW_LEN(CW_LEN)) u_cnt (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (clear),
        .advance_i    (step),
        .batch_idx_o  (batch_idx),
        .last_batch_o (last_batch)
    );

    // ====================
    // evaluation lanes
    // ====================

    for (genvar m = 0; m < LANES; m++) begin : g_lane
        chien_lane #(.LANES(LANES), .LANE_IDX(m)) u_lane (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .load_i  (load),
            .step_i  (step),
            .sigma_i (sigma_q),
            .sum_o   (lane_sum[m])
        );
        // zero sum marks a root
        assign zero_vec[m] = (lane_sum[m] == '0);
    end

    // capture coincides with the step edge
    root_serializer #(.LANES(LANES), .CW_LEN(CW_LEN)) u_ser (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .capture_i    (step),
        .root_ack_i   (root_ack_i),
        .clear_i      (clear),
        .zero_i       (zero_vec),
        .batch_idx_i  (batch_idx),
        .busy_o       (busy),
        .root_req_o   (root_req_o),
        .root_pos_o   (root_pos_o),
        .root_count_o (root_count_o)
    );

endmodule

//--- src/gf_mul.sv
// GF(2^10) multiplier
`timescale 1ns/10ps

module gf_mul (
    input  chien_pkg::gf_elem_t a_i,
    input  chien_pkg::gf_elem_t b_i,
    output chien_pkg::gf_elem_t p_o
);
    import chien_pkg::*;

    // running product and shifted multiplicand
    gf_elem_t acc;
    gf_elem_t shf;

    // shift-and-add, lsb of b first
    always_comb begin
        acc = '0;
        shf = a_i;
        for (int i = 0; i < GF_W; i++) begin
            if (b_i[i]) begin
                acc = acc ^ shf;
            end
            // times alpha, fold x^10 back in via the field polynomial
            shf = {shf[GF_W-2:0], 1'b0} ^ (shf[GF_W-1] ? GF_POLY[GF_W-1:0] : '0);
        end
    end

    assign p_o = acc;

endmodule

//--- src/root_serializer.sv
// root position serializer
`timescale 1ns/10ps

module root_serializer #(
    parameter int LANES  = 4,
    parameter int CW_LEN = 544
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 capture_i,
    input  logic                 root_ack_i,
    input  logic                 clear_i,
    input  logic [LANES-1:0]     zero_i,
    input  chien_pkg::cw_pos_t   batch_idx_i,
    output logic                 busy_o,
    output logic                 root_req_o,
    output chien_pkg::cw_pos_t   root_pos_o,
    output chien_pkg::root_cnt_t root_count_o
);
    import chien_pkg::*;

    localparam int LW = (LANES > 1) ? $clog2(LANES) : 1;

    // pending hits of the captured batch
    logic [LANES-1:0] pend_q;
    logic [LANES-1:0] in_range;
    cw_pos_t          base_q;
    // req up, then waiting for ack to drop
    logic             req_q;
    logic             wait_q;
    cw_pos_t          pos_q;
    cw_pos_t          pos_next;
    root_cnt_t        cnt_q;
    logic [LW-1:0]    sel;
    logic             any_pend;
    logic             launch;

    // lanes past the codeword end are padding
    always_comb begin
        for (int m = 0; m < LANES; m++) begin
            in_range[m] = (int'(batch_idx_i) * LANES + m) < CW_LEN;
        end
    end

    // lowest pending lane first, gives descending positions
    always_comb begin
        sel = '0;
        for (int k = LANES - 1; k >= 0; k--) begin
            if (pend_q[k]) begin
                sel = LW'(k);
            end
        end
    end

    assign any_pend = |pend_q;
    assign launch   = any_pend && !req_q && !wait_q && !root_ack_i;
    // index to codeword position, highest order first
    assign pos_next = cw_pos_t'(CW_LEN - 1 - (int'(base_q) * LANES + int'(sel)));

    // ====================
    // four-phase root handshake
    // ====================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q <= '0;
            req_q  <= 1'b0;
            wait_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            if (capture_i) begin
                pend_q <= zero_i & in_range;
            end else if (req_q && root_ack_i) begin
                pend_q[sel] <= 1'b0;
            end
            if (req_q) begin
                // accepted, count it and drop req
                if (root_ack_i) begin
                    req_q  <= 1'b0;
                    wait_q <= 1'b1;
                    cnt_q  <= cnt_q + 1'b1;
                end
            end else if (wait_q) begin
                if (!root_ack_i) begin
                    wait_q <= 1'b0;
                end
            end else if (launch) begin
                req_q <= 1'b1;
            end
            // new scan restarts the count
            if (clear_i) begin
                cnt_q <= '0;
            end
        end
    end

    // batch base and presented position
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            base_q <= batch_idx_i;
        end
        if (launch) begin
            pos_q <= pos_next;
        end
    end

    assign busy_o       = any_pend || req_q || wait_q;
    assign root_req_o   = req_q;
    assign root_pos_o   = pos_q;
    assign root_count_o = cnt_q;

    // req and position hold until acked
    a_req_hold : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (root_req_o && !root_ack_i) |=> (root_req_o && $stable(root_pos_o))
    );

endmodule

//--- src/scan_ctrl.sv
// chien scan controller
`timescale 1ns/10ps

module scan_ctrl (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic start_req_i,
    input  logic busy_i,
    input  logic last_batch_i,
    output logic start_ack_o,
    output logic sigma_capture_o,
    output logic load_o,
    output logic step_o,
    output logic clear_o,
    output logic done_o
);
    import chien_pkg::*;

    scan_state_e state_q;
    scan_state_e state_d;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ====================
    // next state and strobes
    // ====================

    always_comb begin
        state_d         = state_q;
        sigma_capture_o = 1'b0;
        clear_o         = 1'b0;
        load_o          = 1'b0;
        step_o          = 1'b0;
        case (state_q)
            IDLE: begin
                // grab sigma, reset batch index and root count
                if (start_req_i) begin
                    sigma_capture_o = 1'b1;
                    clear_o         = 1'b1;
                    state_d         = ACK;
                end
            end
            ACK: begin
                // hold ack until requester lets go
                if (!start_req_i) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                load_o  = 1'b1;
                state_d = SCAN;
            end
            SCAN: begin
                // step only while serializer is free
                step_o = !busy_i;
                if (!busy_i && last_batch_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // wait out hits of the final batch
                if (!busy_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign start_ack_o = (state_q == ACK);
    assign done_o      = (state_q == DONE);

    // no step into a serializer still draining
    a_step_not_busy : assert property (
        @(posedge clk_i) disable iff (!rst_ni) step_o |-> !busy_i
    );

    // serializer only gets busy from a capture
    a_busy_after_step : assert property (
        @(posedge clk_i) disable iff (!rst_ni) $rose(busy_i) |-> $past(step_o)
    );

endmodule
